//--- ru_cfg.svh
`ifndef RU_CFG_SVH
`define RU_CFG_SVH

// register word addresses
`define RU_ADDR_WR_CTRL   4'd0
`define RU_ADDR_WR_FIFO   4'd1
`define RU_ADDR_WR_FLAG   4'd2
`define RU_ADDR_HOTRESET  4'd8
`define RU_ADDR_VERSION   4'd9
`define RU_ADDR_LAST      4'd9    // highest mapped word

// returned on reads of the version word
`define RU_FPGA_VERSION   32'h0001_0200

// bitstream path
`define RU_FIFO_WORDS     512     // power of two
`define RU_PACKET_BYTES   256

// bus response codes
`define RU_RESP_OKAY      2'b00
`define RU_RESP_SLVERR    2'b10

`endif

//--- ru_pkg.sv
package ru_pkg;

    typedef struct packed {
        logic [3:0]  id;
        logic [31:0] addr;
        logic [7:0]  len;     // beats minus one
        logic [1:0]  burst;
    } axi_aw_t;

    typedef axi_aw_t axi_ar_t;   // read address carries the same fields

    typedef struct packed {
        logic [31:0] data;
        logic [3:0]  strb;
        logic        last;
    } axi_w_t;

    typedef struct packed {
        logic [3:0] id;
        logic [1:0] resp;
    } axi_b_t;

    typedef struct packed {
        logic [3:0]  id;
        logic [31:0] data;
        logic [1:0]  resp;
        logic        last;
    } axi_r_t;

    // one accepted write beat towards the register bank
    typedef struct packed {
        logic [3:0]  addr;
        logic [31:0] data;
        logic [3:0]  strb;
    } reg_wr_t;

    typedef struct packed {
        logic        en;             // single cycle start pulse
        logic [11:0] start_sector;
        logic [15:0] sector_num;
    } flash_wr_ctrl_t;

    typedef struct packed {
        logic        en;
        logic [23:0] addr;
    } hotreset_t;

endpackage

//--- axi_wr_channel.sv
`timescale 1ns/1ps
`include "ru_cfg.svh"

module axi_wr_channel import ru_pkg::*; (
    input  logic        clk,
    input  logic        SLAVE_RSTN_SYNC,
    input  axi_aw_t     aw,
    input  logic        aw_valid,
    output logic        aw_ready,
    input  axi_w_t      w,
    input  logic        w_valid,
    output logic        w_ready,
    output axi_b_t      b,
    output logic        b_valid,
    input  logic        b_ready,
    input  logic        fifo_full,
    output logic        reg_wr_valid,
    output reg_wr_t     reg_wr,
    output logic        fifo_push,
    output logic [31:0] fifo_word
);

    typedef enum logic [1:0] {WR_IDLE, WR_DATA, WR_RESP} wr_state_t;

    wr_state_t   state;
    logic [3:0]  wr_id;
    logic [31:0] wr_addr;
    logic [1:0]  wr_burst;
    logic        wr_err;     // sticky over the burst
    logic        aw_fire;
    logic        w_fire;
    logic        in_range;
    logic        hit_ctrl;
    logic        hit_fifo;
    logic        hit_hot;
    logic        bad_burst;
    logic        beat_err;

    assign aw_fire = aw_valid && aw_ready;
    assign w_fire  = w_valid && w_ready;

    // only 0, 1 and 8 take writes
    assign in_range  = (wr_addr[31:4] == '0);
    assign hit_ctrl  = in_range && (wr_addr[3:0] == `RU_ADDR_WR_CTRL);
    assign hit_fifo  = in_range && (wr_addr[3:0] == `RU_ADDR_WR_FIFO);
    assign hit_hot   = in_range && (wr_addr[3:0] == `RU_ADDR_HOTRESET);
    assign bad_burst = wr_burst[1];    // wrap and reserved
    assign beat_err  = bad_burst || !(hit_ctrl || hit_fifo || hit_hot);

    assign aw_ready = (state == WR_IDLE);
    assign b_valid  = (state == WR_RESP);
    assign b.id     = wr_id;
    assign b.resp   = wr_err ? `RU_RESP_SLVERR : `RU_RESP_OKAY;

    always_comb begin
        w_ready = 1'b0;
        if (state == WR_DATA)
            w_ready = hit_fifo ? !fifo_full : 1'b1;   // fifo beats wait for room
    end

    // error beats are accepted and dropped here
    assign reg_wr_valid = w_fire && (hit_ctrl || hit_hot) && !bad_burst;
    assign reg_wr.addr  = wr_addr[3:0];
    assign reg_wr.data  = w.data;
    assign reg_wr.strb  = w.strb;
    assign fifo_push    = w_fire && hit_fifo && !bad_burst;
    assign fifo_word    = w.data;

    always_ff @(posedge clk or negedge SLAVE_RSTN_SYNC) begin
        if (!SLAVE_RSTN_SYNC) begin
            state  <= WR_IDLE;
            wr_err <= 1'b0;
        end else begin
            case (state)
                WR_IDLE: begin
                    if (aw_fire) begin
                        state  <= WR_DATA;
                        wr_err <= 1'b0;
                    end
                end
                WR_DATA: begin
                    if (w_fire) begin
                        wr_err <= wr_err | beat_err;
                        if (w.last)
                            state <= WR_RESP;
                    end
                end
                WR_RESP: begin
                    if (b_ready)
                        state <= WR_IDLE;
                end
                default: state <= WR_IDLE;
            endcase
        end
    end

    // burst context, walks forward on incr bursts
    always_ff @(posedge clk) begin
        if (aw_fire) begin
            wr_id    <= aw.id;
            wr_addr  <= aw.addr;
            wr_burst <= aw.burst;
        end else if (w_fire && (wr_burst == 2'b01)) begin
            wr_addr <= wr_addr + 32'd1;
        end
    end

endmodule

//--- axi_rd_channel.sv
`timescale 1ns/1ps
`include "ru_cfg.svh"

module axi_rd_channel import ru_pkg::*; (
    input  logic        clk,
    input  logic        SLAVE_RSTN_SYNC,
    input  axi_ar_t     ar,
    input  logic        ar_valid,
    output logic        ar_ready,
    output axi_r_t      r,
    output logic        r_valid,
    input  logic        r_ready,
    output logic [3:0]  rd_addr,
    input  logic [31:0] rd_data
);

    typedef enum logic {RD_IDLE, RD_DATA} rd_state_t;

    rd_state_t   state;
    logic [3:0]  rd_id;
    logic [31:0] cur_addr;
    logic [7:0]  rd_len;
    logic [1:0]  rd_burst;
    logic [7:0]  beat_cnt;
    logic        ar_fire;
    logic        r_fire;
    logic        last_beat;
    logic        addr_ok;

    assign ar_fire   = ar_valid && ar_ready;
    assign r_fire    = r_valid && r_ready;
    assign last_beat = (beat_cnt == rd_len);

    assign ar_ready = (state == RD_IDLE);
    assign r_valid  = (state == RD_DATA);
    assign rd_addr  = cur_addr[3:0];

    // readable: control, flags, hot reset and version
    assign addr_ok = (cur_addr[31:4] == '0) &&
                     ((rd_addr == `RU_ADDR_WR_CTRL) || (rd_addr == `RU_ADDR_WR_FLAG) ||
                      ((rd_addr >= `RU_ADDR_HOTRESET) && (rd_addr <= `RU_ADDR_LAST)));

    assign r.id   = rd_id;
    assign r.data = rd_data;
    assign r.resp = (addr_ok && !rd_burst[1]) ? `RU_RESP_OKAY : `RU_RESP_SLVERR;
    assign r.last = r_valid && last_beat;

    always_ff @(posedge clk or negedge SLAVE_RSTN_SYNC) begin
        if (!SLAVE_RSTN_SYNC) begin
            state    <= RD_IDLE;
            beat_cnt <= '0;
        end else if (state == RD_IDLE) begin
            beat_cnt <= '0;
            if (ar_fire)
                state <= RD_DATA;
        end else if (r_fire) begin
            beat_cnt <= beat_cnt + 8'd1;
            if (last_beat)
                state <= RD_IDLE;
        end
    end

    always_ff @(posedge clk) begin
        if (ar_fire) begin
            rd_id    <= ar.id;
            cur_addr <= ar.addr;
            rd_len   <= ar.len;
            rd_burst <= ar.burst;
        end else if (r_fire && (rd_burst == 2'b01)) begin
            cur_addr <= cur_addr + 32'd1;
        end
    end

    // count never runs past len so last always shows up
    a_cnt_in_len: assert property (@(posedge clk) disable iff (!SLAVE_RSTN_SYNC)
        r_valid |-> (beat_cnt <= rd_len));

endmodule

//--- ru_reg_bank.sv
`timescale 1ns/1ps
`include "ru_cfg.svh"

module ru_reg_bank import ru_pkg::*; (
    input  logic           clk,
    input  logic           SLAVE_RSTN_SYNC,
    input  logic           reg_wr_valid,
    input  reg_wr_t        reg_wr,
    input  logic [3:0]     rd_addr,
    input  logic           fifo_full,
    input  logic           fifo_empty,
    input  logic           flash_wr_done,
    input  logic           flash_clear_done,
    output flash_wr_ctrl_t flash_wr_ctrl,
    output hotreset_t      hotreset,
    output logic [31:0]    rd_data
);

    logic wr_ctrl;
    logic wr_hot;

    assign wr_ctrl = reg_wr_valid && (reg_wr.addr == `RU_ADDR_WR_CTRL);
    assign wr_hot  = reg_wr_valid && (reg_wr.addr == `RU_ADDR_HOTRESET);

    // flash write control, en only lasts one cycle
    always_ff @(posedge clk or negedge SLAVE_RSTN_SYNC) begin
        if (!SLAVE_RSTN_SYNC) begin
            flash_wr_ctrl <= '0;
        end else begin
            flash_wr_ctrl.en <= 1'b0;
            if (wr_ctrl) begin
                if (reg_wr.strb[3])
                    flash_wr_ctrl.sector_num[15:8] <= reg_wr.data[31:24];
                if (reg_wr.strb[2])
                    flash_wr_ctrl.sector_num[7:0] <= reg_wr.data[23:16];
                if (reg_wr.strb[1]) begin
                    flash_wr_ctrl.en                 <= reg_wr.data[15];
                    flash_wr_ctrl.start_sector[11:8] <= reg_wr.data[11:8];
                end
                if (reg_wr.strb[0])
                    flash_wr_ctrl.start_sector[7:0] <= reg_wr.data[7:0];
            end
        end
    end

    // hot reset target and enable, both held
    always_ff @(posedge clk or negedge SLAVE_RSTN_SYNC) begin
        if (!SLAVE_RSTN_SYNC) begin
            hotreset <= '0;
        end else if (wr_hot) begin
            if (reg_wr.strb[3])
                hotreset.addr[23:16] <= reg_wr.data[31:24];
            if (reg_wr.strb[2])
                hotreset.addr[15:8] <= reg_wr.data[23:16];
            if (reg_wr.strb[1])
                hotreset.addr[7:0] <= reg_wr.data[15:8];
            if (reg_wr.strb[0])
                hotreset.en <= reg_wr.data[0];
        end
    end

    always_comb begin
        case (rd_addr)
            `RU_ADDR_WR_CTRL:
                rd_data = {flash_wr_ctrl.sector_num, 4'b0, flash_wr_ctrl.start_sector};
            `RU_ADDR_WR_FLAG:
                rd_data = {7'b0, fifo_full, 7'b0, fifo_empty,
                           7'b0, flash_wr_done, 7'b0, flash_clear_done};   // one flag per byte
            `RU_ADDR_HOTRESET:
                rd_data = {hotreset.addr, 7'b0, hotreset.en};
            `RU_ADDR_VERSION:
                rd_data = `RU_FPGA_VERSION;
            default:
                rd_data = 32'hFFFF_FFFF;
        endcase
    end

endmodule

//--- bitstream_fifo.sv
`timescale 1ns/1ps
`include "ru_cfg.svh"

module bitstream_fifo (
    input  logic        clk,
    input  logic        SLAVE_RSTN_SYNC,
    input  logic        fifo_push,
    input  logic [31:0] fifo_word,
    input  logic        pop,
    output logic [7:0]  byte_out,
    output logic        fifo_full,
    output logic        fifo_empty,
    output logic [11:0] level
);

    localparam int DEPTH = `RU_FIFO_WORDS;
    localparam int AW    = $clog2(DEPTH);

    logic [31:0] mem [DEPTH];
    logic [AW:0] wr_ptr;
    logic [AW:0] rd_ptr;
    logic [AW:0] word_cnt;
    logic [31:0] cur_word;    // word being handed out
    logic        cur_valid;
    logic [1:0]  sel;         // byte lane of cur_word
    logic        mem_empty;
    logic        load;

    assign word_cnt  = wr_ptr - rd_ptr;
    assign mem_empty = (word_cnt == '0);
    assign fifo_full = word_cnt[AW];
    assign fifo_empty = mem_empty && !cur_valid;

    // refill when idle or as the last lane goes out
    assign load = !mem_empty && (!cur_valid || (pop && (sel == 2'd3)));

    assign byte_out = cur_word[8*sel +: 8];   // lsb first
    assign level    = 12'({word_cnt, 2'b00}) + (cur_valid ? 12'(3'd4 - sel) : 12'd0);

    always_ff @(posedge clk) begin
        if (fifo_push)
            mem[wr_ptr[AW-1:0]] <= fifo_word;
    end

    always_ff @(posedge clk) begin
        if (load)
            cur_word <= mem[rd_ptr[AW-1:0]];
    end

    always_ff @(posedge clk or negedge SLAVE_RSTN_SYNC) begin
        if (!SLAVE_RSTN_SYNC) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            cur_valid <= 1'b0;
            sel       <= 2'd0;
        end else begin
            if (fifo_push)
                wr_ptr <= wr_ptr + 1'b1;
            if (load) begin
                rd_ptr    <= rd_ptr + 1'b1;
                cur_valid <= 1'b1;
                sel       <= 2'd0;
            end else if (pop) begin
                sel <= sel + 2'd1;
                if (sel == 2'd3)
                    cur_valid <= 1'b0;   // drained
            end
        end
    end

    // push comes from the write channel
    a_no_push_full: assert property (@(posedge clk) disable iff (!SLAVE_RSTN_SYNC)
        fifo_push |-> !fifo_full);

    // pop is driven by the packetizer
    a_no_pop_empty: assert property (@(posedge clk) disable iff (!SLAVE_RSTN_SYNC)
        pop |-> !fifo_empty);

endmodule

//--- bitstream_packetizer.sv
`timescale 1ns/1ps
`include "ru_cfg.svh"

module bitstream_packetizer (
    input  logic        clk,
    input  logic        SLAVE_RSTN_SYNC,
    input  logic [11:0] level,
    input  logic        bitstream_fifo_rd_req,
    output logic        bitstream_fifo_rd_rdy,
    output logic        bitstream_valid,
    output logic        bitstream_eop,
    output logic        pop
);

    localparam int PKT = `RU_PACKET_BYTES;
    localparam int CW  = $clog2(PKT);

    typedef enum logic {PK_IDLE, PK_XFER} pk_state_t;

    pk_state_t     state;
    logic [CW-1:0] byte_cnt;   // bytes sent in this packet

    assign bitstream_fifo_rd_rdy = (state == PK_XFER);
    assign bitstream_valid       = bitstream_fifo_rd_rdy && bitstream_fifo_rd_req;
    assign pop                   = bitstream_valid;
    assign bitstream_eop         = bitstream_valid && (byte_cnt == CW'(PKT - 1));

    always_ff @(posedge clk or negedge SLAVE_RSTN_SYNC) begin
        if (!SLAVE_RSTN_SYNC) begin
            state    <= PK_IDLE;
            byte_cnt <= '0;
        end else if (state == PK_IDLE) begin
            byte_cnt <= '0;
            if (level >= 12'(PKT))   // whole packet on hand
                state <= PK_XFER;
        end else if (bitstream_valid) begin
            byte_cnt <= byte_cnt + 1'b1;
            if (bitstream_eop)
                state <= PK_IDLE;
        end
    end

endmodule

//--- ru_slave_top.sv
`timescale 1ns/1ps

module ru_slave_top import ru_pkg::*; (
    input  logic           clk,
    input  logic           SLAVE_RSTN_SYNC,
    input  axi_aw_t        aw,
    input  logic           aw_valid,
    output logic           aw_ready,
    input  axi_w_t         w,
    input  logic           w_valid,
    output logic           w_ready,
    output axi_b_t         b,
    output logic           b_valid,
    input  logic           b_ready,
    input  axi_ar_t        ar,
    input  logic           ar_valid,
    output logic           ar_ready,
    output axi_r_t         r,
    output logic           r_valid,
    input  logic           r_ready,
    output flash_wr_ctrl_t flash_wr_ctrl,
    output hotreset_t      hotreset,
    input  logic           flash_wr_done,
    input  logic           flash_clear_done,
    input  logic           bitstream_fifo_rd_req,
    output logic           bitstream_fifo_rd_rdy,
    output logic           bitstream_valid,
    output logic [7:0]     bitstream_data,
    output logic           bitstream_eop
);

    reg_wr_t     reg_wr;
    logic        reg_wr_valid;
    logic        fifo_push;
    logic [31:0] fifo_word;
    logic        fifo_full;
    logic        fifo_empty;
    logic [11:0] level;
    logic        pop;
    logic [3:0]  rd_addr;
    logic [31:0] rd_data;

    axi_wr_channel axi_wr_channel_inst (
        .clk             (clk),
        .SLAVE_RSTN_SYNC (SLAVE_RSTN_SYNC),
        .aw              (aw),
        .aw_valid        (aw_valid),
        .aw_ready        (aw_ready),
        .w               (w),
        .w_valid         (w_valid),
        .w_ready         (w_ready),
        .b               (b),
        .b_valid         (b_valid),
        .b_ready         (b_ready),
        .fifo_full       (fifo_full),
        .reg_wr_valid    (reg_wr_valid),
        .reg_wr          (reg_wr),
        .fifo_push       (fifo_push),
        .fifo_word       (fifo_word)
    );

    axi_rd_channel axi_rd_channel_inst (
        .clk             (clk),
        .SLAVE_RSTN_SYNC (SLAVE_RSTN_SYNC),
        .ar              (ar),
        .ar_valid        (ar_valid),
        .ar_ready        (ar_ready),
        .r               (r),
        .r_valid         (r_valid),
        .r_ready         (r_ready),
        .rd_addr         (rd_addr),
        .rd_data         (rd_data)
    );

    ru_reg_bank ru_reg_bank_inst (
        .clk              (clk),
        .SLAVE_RSTN_SYNC  (SLAVE_RSTN_SYNC),
        .reg_wr_valid     (reg_wr_valid),
        .reg_wr           (reg_wr),
        .rd_addr          (rd_addr),
        .fifo_full        (fifo_full),
        .fifo_empty       (fifo_empty),
        .flash_wr_done    (flash_wr_done),
        .flash_clear_done (flash_clear_done),
        .flash_wr_ctrl    (flash_wr_ctrl),
        .hotreset         (hotreset),
        .rd_data          (rd_data)
    );

    bitstream_fifo bitstream_fifo_inst (
        .clk             (clk),
        .SLAVE_RSTN_SYNC (SLAVE_RSTN_SYNC),
        .fifo_push       (fifo_push),
        .fifo_word       (fifo_word),
        .pop             (pop),
        .byte_out        (bitstream_data),   // straight to the flash writer
        .fifo_full       (fifo_full),
        .fifo_empty      (fifo_empty),
        .level           (level)
    );

    bitstream_packetizer bitstream_packetizer_inst (
        .clk                   (clk),
        .SLAVE_RSTN_SYNC       (SLAVE_RSTN_SYNC),
        .level                 (level),
        .bitstream_fifo_rd_req (bitstream_fifo_rd_req),
        .bitstream_fifo_rd_rdy (bitstream_fifo_rd_rdy),
        .bitstream_valid       (bitstream_valid),
        .bitstream_eop         (bitstream_eop),
        .pop                   (pop)
    );

endmodule

//--- tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen (
    output logic clk
);

    localparam int HALF_NS = 50;   // 100 ns period

    initial clk = 1'b0;

    always #(HALF_NS) clk = ~clk;

endmodule

//--- tb_ru_slave.sv
`timescale 1ns/1ps
`include "ru_cfg.svh"

module tb_ru_slave import ru_pkg::*; ();

    localparam int N_REG      = 40;   // register writes, each read back
    localparam int N_ERR      = 30;
    localparam int N_RBURST   = 6;
    localparam int N_WORDS    = 640;  // ten packets, more than the FIFO holds
    localparam int N_FLAG     = 8;
    localparam int MAX_CYCLES = 100 + 40 * (N_REG + N_ERR + N_FLAG) + 80 * N_RBURST
                                + 40 * N_WORDS;

    logic           clk;
    logic           SLAVE_RSTN_SYNC;
    axi_aw_t        aw;
    logic           aw_valid;
    logic           aw_ready;
    axi_w_t         w;
    logic           w_valid;
    logic           w_ready;
    axi_b_t         b;
    logic           b_valid;
    logic           b_ready;
    axi_ar_t        ar;
    logic           ar_valid;
    logic           ar_ready;
    axi_r_t         r;
    logic           r_valid;
    logic           r_ready;
    flash_wr_ctrl_t flash_wr_ctrl;
    hotreset_t      hotreset;
    logic           flash_wr_done;
    logic           flash_clear_done;
    logic           bitstream_fifo_rd_req;
    logic           bitstream_fifo_rd_rdy;
    logic           bitstream_valid;
    logic [7:0]     bitstream_data;
    logic           bitstream_eop;

    // reference model
    flash_wr_ctrl_t ctrl_m = '0;
    hotreset_t      hot_m = '0;
    logic [7:0]     byte_q[$];
    logic [7:0]     exp_byte;
    int             byte_cnt = 0;     // position inside the current packet
    logic           rdy_prev = 1'b0;
    logic           eop_prev = 1'b0;
    int             cycles = 0;

    tb_clk_gen tb_clk_gen_inst (.clk(clk));

    ru_slave_top ru_slave_top_inst (.*);

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("SIMULATION FAILED");
        $fatal(1);
    endtask

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic compare_b(input axi_b_t got, input axi_b_t exp);
        if (got !== exp)
            fail_run($sformatf("ERROR b: got %h expected %h", got, exp));
    endtask

    // data only matters on an OKAY beat
    task automatic compare_r(input axi_r_t got, input axi_r_t exp);
        if (got.id !== exp.id || got.resp !== exp.resp || got.last !== exp.last ||
            (exp.resp == `RU_RESP_OKAY && got.data !== exp.data))
            fail_run($sformatf("ERROR r: got %h expected %h", got, exp));
    endtask

    task automatic compare_ctrl(input flash_wr_ctrl_t got, input flash_wr_ctrl_t exp);
        if (got !== exp)
            fail_run($sformatf("ERROR flash_wr_ctrl: got %h expected %h", got, exp));
    endtask

    task automatic compare_hot(input hotreset_t got, input hotreset_t exp);
        if (got !== exp)
            fail_run($sformatf("ERROR hotreset: got %h expected %h", got, exp));
    endtask

    task automatic compare_byte(input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp)
            fail_run($sformatf("ERROR bitstream_data: got %h expected %h", got, exp));
    endtask

    task automatic compare_eop(input logic got, input logic exp);
        if (got !== exp)
            fail_run($sformatf("ERROR bitstream_eop: got %h expected %h", got, exp));
    endtask

    // en is a pulse, so it is cleared once it has been seen
    task automatic check_regs();
        compare_ctrl(flash_wr_ctrl, ctrl_m);
        compare_hot(hotreset, hot_m);
        ctrl_m.en = 1'b0;
    endtask

    // one accepted write beat, err set for a discarded beat
    task automatic model_beat(input logic [31:0] a, input logic [1:0] burst,
                              input axi_w_t beat, output logic err);
        err = 1'b1;
        if (!burst[1] && a == {28'd0, `RU_ADDR_WR_CTRL}) begin
            err = 1'b0;
            if (beat.strb[3])
                ctrl_m.sector_num[15:8] = beat.data[31:24];
            if (beat.strb[2])
                ctrl_m.sector_num[7:0] = beat.data[23:16];
            if (beat.strb[1])
                ctrl_m.start_sector[11:8] = beat.data[11:8];
            if (beat.strb[0])
                ctrl_m.start_sector[7:0] = beat.data[7:0];
            ctrl_m.en = beat.strb[1] && beat.data[15];
        end else if (!burst[1] && a == {28'd0, `RU_ADDR_HOTRESET}) begin
            err = 1'b0;
            if (beat.strb[3])
                hot_m.addr[23:16] = beat.data[31:24];
            if (beat.strb[2])
                hot_m.addr[15:8] = beat.data[23:16];
            if (beat.strb[1])
                hot_m.addr[7:0] = beat.data[15:8];
            if (beat.strb[0])
                hot_m.en = beat.data[0];
        end else if (!burst[1] && a == {28'd0, `RU_ADDR_WR_FIFO}) begin
            err = 1'b0;
            for (int k = 0; k < 4; k++)
                byte_q.push_back(beat.data[8*k +: 8]);   // lsb first
        end
    endtask

    // flags are only read while the FIFO is not full
    function automatic axi_r_t expect_r(input logic [3:0] tag, input logic [31:0] a,
                                        input logic [1:0] burst, input logic last);
        axi_r_t e;
        logic   empty_m;
        empty_m = (byte_q.size() == 0);
        e.id   = tag;
        e.last = last;
        e.data = 32'hFFFF_FFFF;
        e.resp = `RU_RESP_SLVERR;
        if (a < 32'd16 && !burst[1]) begin
            e.resp = `RU_RESP_OKAY;
            case (a[3:0])
                `RU_ADDR_WR_CTRL:
                    e.data = {ctrl_m.sector_num, 4'h0, ctrl_m.start_sector};
                `RU_ADDR_WR_FLAG:
                    e.data = {8'd0, 7'd0, empty_m, 7'd0, flash_wr_done, 7'd0, flash_clear_done};
                `RU_ADDR_HOTRESET:
                    e.data = {hot_m.addr, 7'd0, hot_m.en};
                `RU_ADDR_VERSION:
                    e.data = `RU_FPGA_VERSION;
                default:
                    e.resp = `RU_RESP_SLVERR;
            endcase
        end
        return e;
    endfunction

    function automatic logic [31:0] unmapped_addr();
        case ($urandom_range(2))
            0:       return 32'($urandom_range(7, 3));
            1:       return 32'($urandom_range(15, 10));
            default: return $urandom | 32'h10;   // above the map
        endcase
    endfunction

    task automatic do_write(input logic [31:0] addr, input logic [7:0] len,
                            input logic [1:0] burst);
        axi_b_t      exp_b;
        axi_w_t      beat;
        logic        err;
        logic        beat_err;
        logic        done;
        logic [31:0] a;
        int          i;
        exp_b.id = 4'($urandom);
        err = 1'b0;
        aw = '{id: exp_b.id, addr: addr, len: len, burst: burst};
        aw_valid = 1'b1;
        do begin
            @(negedge clk);
            check_regs();
        end while (!aw_ready);
        step();
        aw_valid = 1'b0;
        for (i = 0; i <= int'(len); i++) begin
            beat.data = $urandom;
            beat.strb = 4'($urandom);
            beat.last = (i == int'(len));
            w = beat;
            w_valid = 1'b1;
            do begin
                @(negedge clk);
                check_regs();
            end while (!w_ready);
            step();
            w_valid = 1'b0;
            a = (burst == 2'b01) ? addr + 32'(i) : addr;
            model_beat(a, burst, beat, beat_err);
            err = err | beat_err;
        end
        exp_b.resp = err ? `RU_RESP_SLVERR : `RU_RESP_OKAY;
        b_ready = 1'($urandom);
        do begin
            @(negedge clk);
            check_regs();
            if (!b_valid)
                fail_run("b_valid was low while a write response was due");
            compare_b(b, exp_b);
            done = b_ready;
            step();
            b_ready = 1'($urandom);
        end while (!done);
        b_ready = 1'b0;
        @(negedge clk);
        check_regs();   // en pulse must be gone by now
        step();
    endtask

    task automatic do_read(input logic [31:0] addr, input logic [7:0] len,
                           input logic [1:0] burst);
        axi_r_t      exp_r;
        logic [3:0]  tag;
        logic [31:0] a;
        int          beat;
        tag = 4'($urandom);
        ar = '{id: tag, addr: addr, len: len, burst: burst};
        ar_valid = 1'b1;
        do begin
            @(negedge clk);
        end while (!ar_ready);
        step();
        ar_valid = 1'b0;
        r_ready = 1'($urandom);
        beat = 0;
        while (beat <= int'(len)) begin
            @(negedge clk);
            if (!r_valid)
                fail_run("r_valid was low while a read beat was due");
            a = (burst == 2'b01) ? addr + 32'(beat) : addr;
            exp_r = expect_r(tag, a, burst, beat == int'(len));
            compare_r(r, exp_r);     // also holds while r_ready is low
            if (r_ready)
                beat++;
            step();
            r_ready = 1'($urandom);
        end
        r_ready = 1'b0;
    endtask

    // flash writer side, one request per byte
    initial begin
        bitstream_fifo_rd_req = 1'b0;
        forever begin
            step();
            bitstream_fifo_rd_req = SLAVE_RSTN_SYNC && bitstream_fifo_rd_rdy &&
                                    ($urandom_range(3) == 0);
        end
    end

    always @(negedge clk) begin
        if (SLAVE_RSTN_SYNC) begin
            if (bitstream_valid !== bitstream_fifo_rd_req)
                fail_run("bitstream_valid does not follow the rd_req pulse");
            if (bitstream_fifo_rd_rdy && !rdy_prev && byte_q.size() < `RU_PACKET_BYTES)
                fail_run("bitstream_fifo_rd_rdy rose before a whole packet was stored");
            if (!bitstream_fifo_rd_rdy && rdy_prev && !eop_prev)
                fail_run("bitstream_fifo_rd_rdy dropped in the middle of a packet");
            if (bitstream_valid) begin
                if (byte_q.size() == 0)
                    fail_run("a bitstream byte came out that was never written");
                exp_byte = byte_q.pop_front();
                compare_byte(bitstream_data, exp_byte);
                compare_eop(bitstream_eop, byte_cnt == `RU_PACKET_BYTES - 1);
                byte_cnt = (byte_cnt + 1) % `RU_PACKET_BYTES;
            end else if (bitstream_eop) begin
                fail_run("bitstream_eop was high without a byte");
            end
            rdy_prev = bitstream_fifo_rd_rdy;
            eop_prev = bitstream_eop;
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= MAX_CYCLES)
            fail_run($sformatf("timeout, the run did not end within %0d cycles", MAX_CYCLES));
    end

    initial begin
        int          n;
        int          left;
        int          start;
        logic [1:0]  burst;
        logic [31:0] addr;
        void'($urandom(32'h95a800a8));
        SLAVE_RSTN_SYNC  = 1'b0;
        aw               = '0;
        aw_valid         = 1'b0;
        w                = '0;
        w_valid          = 1'b0;
        b_ready          = 1'b0;
        ar               = '0;
        ar_valid         = 1'b0;
        r_ready          = 1'b0;
        flash_wr_done    = 1'b0;
        flash_clear_done = 1'b0;
        repeat (4) @(posedge clk);
        #1;
        SLAVE_RSTN_SYNC = 1'b1;
        @(negedge clk);
        if (!aw_ready || !ar_ready || b_valid || r_valid || flash_wr_ctrl.en ||
            hotreset.en || bitstream_fifo_rd_rdy)
            fail_run("outputs are not in their reset state after reset");
        check_regs();
        step();

        // register writes, each read back
        for (n = 0; n < N_REG; n++) begin
            addr = $urandom_range(1) ? 32'(`RU_ADDR_HOTRESET) : 32'(`RU_ADDR_WR_CTRL);
            do_write(addr, 8'd0, 2'($urandom_range(1)));
            do_read(addr, 8'd0, 2'b01);
        end

        // error cases
        for (n = 0; n < N_ERR; n++) begin
            case ($urandom_range(4))
                0: do_write($urandom_range(1) ? 32'd2 : 32'd9, 8'($urandom_range(2)), 2'b00);
                1: do_write(unmapped_addr(), 8'($urandom_range(2)), 2'b00);
                2: do_read(unmapped_addr(), 8'($urandom_range(2)), 2'b00);
                3: do_read(32'(`RU_ADDR_WR_FIFO), 8'($urandom_range(2)), 2'b00);
                default: begin
                    burst = 2'($urandom_range(3, 2));   // wrap or reserved
                    if ($urandom_range(1))
                        do_write(32'($urandom_range(8)), 8'($urandom_range(2)), burst);
                    else
                        do_read(32'($urandom_range(9)), 8'($urandom_range(2)), burst);
                end
            endcase
        end

        // incrementing read bursts across the map, first one covers all ten words
        for (n = 0; n < N_RBURST; n++) begin
            flash_wr_done    = 1'($urandom);
            flash_clear_done = 1'($urandom);
            start = (n == 0) ? 0 : $urandom_range(9);
            do_read(32'(start), (n == 0) ? 8'd9 : 8'($urandom_range(9 - start)), 2'b01);
        end

        // bitstream words, fixed bursts so every beat hits the data port
        left = N_WORDS;
        while (left > 0) begin
            n = $urandom_range(32, 1);
            if (n > left)
                n = left;
            do_write(32'(`RU_ADDR_WR_FIFO), 8'(n - 1), 2'b00);
            left = left - n;
        end
        while (byte_q.size() != 0)
            step();
        repeat (2) step();

        // flags after the drain
        for (n = 0; n < N_FLAG; n++) begin
            flash_wr_done    = 1'($urandom);
            flash_clear_done = 1'($urandom);
            do_read(32'(`RU_ADDR_WR_FLAG), 8'd0, 2'b01);
        end

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

//--- filelist.f
+incdir+.
ru_pkg.sv
axi_wr_channel.sv
axi_rd_channel.sv
ru_reg_bank.sv
bitstream_fifo.sv
bitstream_packetizer.sv
ru_slave_top.sv
tb_clk_gen.sv
tb_ru_slave.sv

//--- run_sim.sh
#!/bin/sh
# compile with Verilator, run, and judge the run from its log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_ru_slave \
    -f filelist.f -o tb_ru_slave \
    && ./obj_dir/tb_ru_slave > sim.log 2>&1 \
    || echo "build or simulation returned an error"

cat sim.log 2>/dev/null
grep -q "SIMULATION PASSED" sim.log && exit 0 || { echo "run failed, see sim.log"; exit 1; }
